// ==== all.f ====
src/fb_pkg.sv
src/mem_port_if.sv
src/pixel_writer.sv
src/mem_arbiter.sv
src/frame_store.sv
src/tft_timing.sv
src/tft_fetch.sv
src/fb_top.sv
tests/fb_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the frame buffer testbench with Verilator, from the project root

verilator --binary --timing -Wno-fatal --top-module fb_tb -f all.f \
	--Mdir obj_dir -o fb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/fb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Pass only if the testbench printed its pass line
if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
echo "Pass message not found"
exit 1

// ==== src/fb_pkg.sv ====
`default_nettype none

package fb_pkg;

	// Visible frame, one word per pixel
	localparam int frame_width = 16;
	localparam int frame_height = 8;
	localparam int frame_words = frame_width * frame_height;

	// Horizontal timing in clocks
	// Counter zero is the first front porch clock, active pixels come last
	localparam int h_front = 2;
	localparam int h_sync = 2;
	localparam int h_back = 4;
	localparam int h_blank_len = h_front + h_sync + h_back;
	localparam int h_total = h_blank_len + frame_width;

	// Vertical timing in lines, same ordering as horizontal
	localparam int v_front = 1;
	localparam int v_sync = 1;
	localparam int v_back = 2;
	localparam int v_blank_len = v_front + v_sync + v_back;
	localparam int v_total = v_blank_len + frame_height;

	// Frame memory
	localparam int addr_bits = 7;
	localparam int mem_words = 1 << addr_bits;
	localparam int read_latency = 2;
	// Enough to count every read still in the pipe
	localparam int inflight_bits = $clog2(read_latency + 1);

	// Scan counter width
	localparam int coord_bits = 5;

	// Queues
	localparam int write_fifo_depth = 4;
	localparam int write_ptr_bits = $clog2(write_fifo_depth);
	localparam int fetch_fifo_depth = 8;
	localparam int fetch_ptr_bits = $clog2(fetch_fifo_depth);

	// One memory word, raw for storage or split as RGB565
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [4:0] red;
			logic [5:0] green;
			logic [4:0] blue;
		} color;
	} pixel_word_t;

endpackage

`default_nettype wire

// ==== src/fb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_top (
	input logic clk,
	input logic reset,
	input logic display_en,
	input logic clear_flags,
	input logic pixel_we,
	input logic [fb_pkg::coord_bits-1:0] x,
	input logic [fb_pkg::coord_bits-1:0] y,
	input logic [23:0] rgb,
	output logic [23:0] tft_rgb,
	output logic de,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank,
	output logic overrun,
	output logic underrun
);

	// Requester buses into the arbiter
	mem_port_if fetch_bus ();
	mem_port_if write_bus ();

	// Arbiter to frame store
	logic mem_en;
	logic mem_we;
	logic [fb_pkg::addr_bits-1:0] mem_addr;
	fb_pkg::pixel_word_t mem_wdata;
	fb_pkg::pixel_word_t mem_rdata;

	// Producer side
	pixel_writer i_writer (
		.clk(clk),
		.reset(reset),
		.pixel_we(pixel_we),
		.x(x),
		.y(y),
		.rgb(rgb),
		.clear_flags(clear_flags),
		.overrun(overrun),
		.mem(write_bus.requester)
	);

	mem_arbiter i_arbiter (
		.clk(clk),
		.reset(reset),
		.fetch_port(fetch_bus.arbiter),
		.write_port(write_bus.arbiter),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	frame_store i_store (
		.clk(clk),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	// Panel scan, coordinates not needed here
	tft_timing i_timing (
		.clk(clk),
		.reset(reset),
		.display_en(display_en),
		.x(),
		.y(),
		.hblank(hblank),
		.vblank(vblank),
		.de(de),
		.hsync(hsync),
		.vsync(vsync)
	);

	// Display side
	tft_fetch i_fetch (
		.clk(clk),
		.reset(reset),
		.de(de),
		.vblank(vblank),
		.clear_flags(clear_flags),
		.mem(fetch_bus.requester),
		.rgb(tft_rgb),
		.underrun(underrun)
	);

endmodule

`default_nettype wire

// ==== src/frame_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_store (
	input logic clk,
	input logic mem_en,
	input logic mem_we,
	input logic [fb_pkg::addr_bits-1:0] mem_addr,
	input fb_pkg::pixel_word_t mem_wdata,
	output fb_pkg::pixel_word_t mem_rdata
);

	logic [15:0] mem [fb_pkg::mem_words];
	logic [fb_pkg::addr_bits-1:0] rd_addr;

	always_ff @(posedge clk) begin
		// Write port
		if (mem_en && mem_we)
			mem[mem_addr] <= mem_wdata.raw;
		// Stage 1, latch the read address
		if (mem_en && !mem_we)
			rd_addr <= mem_addr;
		// Stage 2, array output register
		mem_rdata.raw <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input logic clk,
	input logic reset,
	mem_port_if.arbiter fetch_port,
	mem_port_if.arbiter write_port,
	output logic mem_en,
	output logic mem_we,
	output logic [fb_pkg::addr_bits-1:0] mem_addr,
	output fb_pkg::pixel_word_t mem_wdata,
	input fb_pkg::pixel_word_t mem_rdata
);

	logic [fb_pkg::read_latency-1:0] fetch_pipe;
	logic [fb_pkg::read_latency-1:0] write_pipe;
	logic fetch_read;
	logic write_read;

	// Display fetch always first
	assign fetch_port.grant = fetch_port.req;
	assign write_port.grant = write_port.req && !fetch_port.req;

	// Winner drives the memory
	assign mem_en = fetch_port.req || write_port.req;
	always_comb begin
		if (fetch_port.req) begin
			mem_we = fetch_port.we;
			mem_addr = fetch_port.addr;
			mem_wdata = fetch_port.wdata;
		end else begin
			mem_we = write_port.we;
			mem_addr = write_port.addr;
			mem_wdata = write_port.wdata;
		end
	end

	// Reads accepted this cycle
	assign fetch_read = fetch_port.grant && !fetch_port.we;
	assign write_read = write_port.grant && !write_port.we;

	// Markers follow each read down the store pipeline
	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_pipe <= '0;
			write_pipe <= '0;
		end else begin
			fetch_pipe <= {fetch_pipe[fb_pkg::read_latency-2:0], fetch_read};
			write_pipe <= {write_pipe[fb_pkg::read_latency-2:0], write_read};
		end
	end

	// Data is shared, valid tells the owner
	assign fetch_port.rdata = mem_rdata;
	assign fetch_port.rvalid = fetch_pipe[fb_pkg::read_latency-1];
	assign write_port.rdata = mem_rdata;
	assign write_port.rvalid = write_pipe[fb_pkg::read_latency-1];

endmodule

`default_nettype wire

// ==== src/mem_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;

	// Request level, held until granted
	logic req;
	logic we;
	logic [fb_pkg::addr_bits-1:0] addr;
	fb_pkg::pixel_word_t wdata;

	// Grant is same cycle, read data comes back later
	logic grant;
	fb_pkg::pixel_word_t rdata;
	logic rvalid;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input grant,
		input rdata,
		input rvalid
	);

	modport arbiter (
		input req,
		input we,
		input addr,
		input wdata,
		output grant,
		output rdata,
		output rvalid
	);

endinterface

`default_nettype wire

// ==== src/pixel_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_writer (
	input logic clk,
	input logic reset,
	input logic pixel_we,
	input logic [fb_pkg::coord_bits-1:0] x,
	input logic [fb_pkg::coord_bits-1:0] y,
	input logic [23:0] rgb,
	input logic clear_flags,
	output logic overrun,
	mem_port_if.requester mem
);

	fb_pkg::pixel_word_t in_word;
	logic [31:0] in_linear;
	fb_pkg::pixel_word_t q_word [fb_pkg::write_fifo_depth];
	logic [fb_pkg::addr_bits-1:0] q_addr [fb_pkg::write_fifo_depth];
	logic [fb_pkg::write_ptr_bits-1:0] wr_ptr;
	logic [fb_pkg::write_ptr_bits-1:0] rd_ptr;
	logic [fb_pkg::write_ptr_bits:0] count;
	logic full;
	logic push;
	logic pop;

	// Keep the top bits of each channel
	always_comb begin
		in_word.color.red = rgb[23:19];
		in_word.color.green = rgb[15:10];
		in_word.color.blue = rgb[7:3];
	end

	// Raster address, row major
	assign in_linear = y * fb_pkg::frame_width + x;

	assign full = count == fb_pkg::write_fifo_depth;
	// Strobe while full is lost
	assign push = pixel_we && !full;
	assign pop = mem.req && mem.grant;

	// Head of queue goes out as a write
	assign mem.req = count != 0;
	assign mem.we = 1'b1;
	assign mem.addr = q_addr[rd_ptr];
	assign mem.wdata = q_word[rd_ptr];

	// Queue storage
	always_ff @(posedge clk) begin
		if (push) begin
			q_word[wr_ptr] <= in_word;
			q_addr[wr_ptr] <= in_linear[fb_pkg::addr_bits-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overrun <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Fill level
			if (push && !pop)
				count <= count + 1'b1;
			else if (!push && pop)
				count <= count - 1'b1;
			// Sticky until cleared, a drop wins over clear
			if (pixel_we && full)
				overrun <= 1'b1;
			else if (clear_flags)
				overrun <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/tft_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tft_fetch (
	input logic clk,
	input logic reset,
	input logic de,
	input logic vblank,
	input logic clear_flags,
	mem_port_if.requester mem,
	output logic [23:0] rgb,
	output logic underrun
);

	fb_pkg::pixel_word_t fifo [fb_pkg::fetch_fifo_depth];
	fb_pkg::pixel_word_t head;
	logic [fb_pkg::fetch_ptr_bits-1:0] wr_ptr;
	logic [fb_pkg::fetch_ptr_bits-1:0] rd_ptr;
	logic [fb_pkg::fetch_ptr_bits:0] fill;
	logic [fb_pkg::addr_bits:0] rd_addr;
	logic [fb_pkg::inflight_bits-1:0] inflight;
	logic [fb_pkg::inflight_bits-1:0] discard;
	logic vblank_q;
	logic restart;
	logic finished;
	logic take;
	logic push;
	logic pop;

	// New frame starts when blanking begins
	assign restart = vblank && !vblank_q;
	assign finished = rd_addr == fb_pkg::frame_words;

	// Keep fill plus reads on the way within the FIFO
	assign mem.req = !restart && !finished &&
		(int'(fill) + int'(inflight) < fb_pkg::fetch_fifo_depth);
	assign mem.we = 1'b0;
	assign mem.addr = rd_addr[fb_pkg::addr_bits-1:0];
	assign mem.wdata = '0;
	assign take = mem.req && mem.grant;

	// Returns from before a restart are thrown away
	assign push = mem.rvalid && discard == 0 && !restart;
	assign pop = de && fill != 0;

	// RGB565 to RGB888, top bits repeated into the low bits
	assign head = fifo[rd_ptr];
	always_comb begin
		rgb = '0;
		if (pop)
			rgb = {head.color.red, head.color.red[4:2],
				head.color.green, head.color.green[5:4],
				head.color.blue, head.color.blue[4:2]};
	end

	always_ff @(posedge clk) begin
		if (push)
			fifo[wr_ptr] <= mem.rdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			vblank_q <= 1'b1;
			rd_addr <= '0;
			inflight <= '0;
			discard <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			underrun <= 1'b0;
		end else begin
			vblank_q <= vblank;
			// Outstanding reads, restart does not cancel them in the store
			if (take && !mem.rvalid)
				inflight <= inflight + 1'b1;
			else if (!take && mem.rvalid)
				inflight <= inflight - 1'b1;
			if (restart) begin
				// Whatever is still coming belongs to the old frame
				discard <= mem.rvalid ? inflight - 1'b1 : inflight;
				rd_addr <= '0;
				wr_ptr <= '0;
				rd_ptr <= '0;
				fill <= '0;
			end else begin
				if (mem.rvalid && discard != 0)
					discard <= discard - 1'b1;
				if (take)
					rd_addr <= rd_addr + 1'b1;
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= rd_ptr + 1'b1;
				if (push && !pop)
					fill <= fill + 1'b1;
				else if (!push && pop)
					fill <= fill - 1'b1;
			end
			// Empty FIFO on a visible pixel
			if (de && fill == 0)
				underrun <= 1'b1;
			else if (clear_flags)
				underrun <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/tft_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module tft_timing (
	input logic clk,
	input logic reset,
	input logic display_en,
	output logic [fb_pkg::coord_bits-1:0] x,
	output logic [fb_pkg::coord_bits-1:0] y,
	output logic hblank,
	output logic vblank,
	output logic de,
	output logic hsync,
	output logic vsync
);

	logic [fb_pkg::coord_bits-1:0] h_cnt;
	logic [fb_pkg::coord_bits-1:0] v_cnt;
	logic [fb_pkg::coord_bits-1:0] h_next;
	logic [fb_pkg::coord_bits-1:0] v_next;
	logic [fb_pkg::coord_bits-1:0] h_rel;
	logic [fb_pkg::coord_bits-1:0] v_rel;
	logic h_act;
	logic v_act;

	// Next scan position, parked at zero while disabled
	always_comb begin
		h_next = h_cnt + 1'b1;
		v_next = v_cnt;
		if (!display_en) begin
			h_next = '0;
			v_next = '0;
		end else if (h_cnt == fb_pkg::h_total - 1) begin
			h_next = '0;
			if (v_cnt == fb_pkg::v_total - 1)
				v_next = '0;
			else
				v_next = v_cnt + 1'b1;
		end
	end

	// Region decode of the next position
	assign h_act = h_next >= fb_pkg::h_blank_len;
	assign v_act = v_next >= fb_pkg::v_blank_len;
	// Pixel coordinates inside the active area
	assign h_rel = h_next - fb_pkg::h_blank_len[fb_pkg::coord_bits-1:0];
	assign v_rel = v_next - fb_pkg::v_blank_len[fb_pkg::coord_bits-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
			x <= '0;
			y <= '0;
			// Zero sits in the front porch, so blanked
			hblank <= 1'b1;
			vblank <= 1'b1;
			de <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			x <= h_act ? h_rel : '0;
			y <= v_act ? v_rel : '0;
			hblank <= !h_act;
			vblank <= !v_act;
			de <= h_act && v_act;
			// Sync pulses right after the front porch
			hsync <= h_next >= fb_pkg::h_front && h_next < fb_pkg::h_front + fb_pkg::h_sync;
			vsync <= v_next >= fb_pkg::v_front && v_next < fb_pkg::v_front + fb_pkg::v_sync;
		end
	end

endmodule

`default_nettype wire

// ==== tests/fb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_tb;

	localparam int clk_period = 8;
	localparam int frame_clks = fb_pkg::h_total * fb_pkg::v_total;
	// Generous bound for all write phases together
	localparam int fill_clks = 4 * fb_pkg::frame_words;
	// Seven displayed frames in all plus one spare
	localparam int limit_clks = 8 * frame_clks + fill_clks + 16;
	localparam int burst_max = 40;
	localparam int subset_writes = 32;

	logic clk;
	logic reset;
	logic display_en;
	logic clear_flags;
	logic pixel_we;
	logic [fb_pkg::coord_bits-1:0] x;
	logic [fb_pkg::coord_bits-1:0] y;
	logic [23:0] rgb;
	logic [23:0] tft_rgb;
	logic de;
	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;
	logic overrun;
	logic underrun;

	integer seed;
	// Frame model of RGB565 words
	logic [15:0] model [fb_pkg::frame_words];

	// Display monitor state
	logic watch;
	logic armed;
	logic vblank_prev;
	int frames_done;
	int pix_idx;
	int de_run;
	int de_lines;
	int hs_run;
	int hs_pulses;
	int vs_run;
	int vs_pulses;

	fb_top i_dut (
		.clk(clk),
		.reset(reset),
		.display_en(display_en),
		.clear_flags(clear_flags),
		.pixel_we(pixel_we),
		.x(x),
		.y(y),
		.rgb(rgb),
		.tft_rgb(tft_rgb),
		.de(de),
		.hsync(hsync),
		.vsync(vsync),
		.hblank(hblank),
		.vblank(vblank),
		.overrun(overrun),
		.underrun(underrun)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic end_in_failure();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic report_error(input string what);
		$display("Error at %0t: %s", $time, what);
		end_in_failure();
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, expected);
			end_in_failure();
		end
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [23:0] random_color();
		logic [31:0] word;
		word = $random(seed);
		return word[23:0];
	endfunction

	// Top bits of each channel
	function automatic logic [15:0] pack565(input logic [23:0] color);
		return {color[23:19], color[15:10], color[7:3]};
	endfunction

	// Top bits of each field repeated below it
	function automatic logic [23:0] expand888(input logic [15:0] word);
		return {word[15:11], word[15:13], word[10:5], word[10:9], word[4:0], word[4:2]};
	endfunction

	task automatic drive_pixel(input int addr, input logic [23:0] color);
		pixel_we <= 1'b1;
		x <= fb_pkg::coord_bits'(addr % fb_pkg::frame_width);
		y <= fb_pkg::coord_bits'(addr / fb_pkg::frame_width);
		rgb <= color;
	endtask

	// One strobe followed by one idle clock
	task automatic write_pixel(input int addr, input logic [23:0] color);
		@(posedge clk);
		drive_pixel(addr, color);
		model[addr] = pack565(color);
		@(posedge clk);
		pixel_we <= 1'b0;
	endtask

	// Called on a rising edge and returns there with display off
	task automatic show_frames(input int count);
		@(posedge clk);
		display_en <= 1'b1;
		frames_done = 0;
		armed = 1'b0;
		watch = 1'b1;
		while (frames_done < count)
			@(posedge clk);
		// Blanking just began so fetch restarts now
		watch = 1'b0;
		display_en <= 1'b0;
	endtask

	// Strobe every clock until overrun shows up
	task automatic write_burst(output int last_addr);
		int base;
		int k;
		int addr;
		int pend_addr;
		int accepted;
		logic [23:0] color;
		logic [23:0] pend_color;
		logic seen;
		base = rand_below(fb_pkg::frame_words);
		pend_addr = -1;
		pend_color = '0;
		accepted = 0;
		seen = 1'b0;
		k = 0;
		last_addr = 0;
		while (!seen && k < burst_max) begin
			addr = (base + k) % fb_pkg::frame_words;
			color = random_color();
			drive_pixel(addr, color);
			@(negedge clk);
			// Flag now covers the strobe one clock earlier
			if (overrun) begin
				seen = 1'b1;
			end else if (pend_addr >= 0) begin
				model[pend_addr] = pack565(pend_color);
				accepted = accepted + 1;
			end
			pend_addr = addr;
			pend_color = color;
			k = k + 1;
			@(posedge clk);
		end
		pixel_we <= 1'b0;
		if (!seen)
			report_error("overrun never set during a write burst");
		else if (accepted < fb_pkg::write_fifo_depth)
			report_error($sformatf("overrun set after only %0d accepted writes", accepted));
		else
			// Last strobe may or may not have been taken
			last_addr = pend_addr;
	endtask

	// Raster and sync checks sampled mid-cycle
	always @(negedge clk) begin
		if (watch && armed) begin
			if (de) begin
				if (pix_idx >= fb_pkg::frame_words) begin
					report_error("more de cycles than pixels in one frame");
				end else begin
					check_equal("tft_rgb", tft_rgb, expand888(model[pix_idx]));
					pix_idx = pix_idx + 1;
					de_run = de_run + 1;
				end
			end else if (de_run != 0) begin
				check_equal("de cycles per line", de_run, fb_pkg::frame_width);
				de_lines = de_lines + 1;
				de_run = 0;
			end
			// Outside vertical blanking only the line position blanks
			if (!vblank)
				check_equal("hblank", hblank, !de);
			if (hsync) begin
				hs_run = hs_run + 1;
			end else if (hs_run != 0) begin
				check_equal("hsync length", hs_run, fb_pkg::h_sync);
				hs_pulses = hs_pulses + 1;
				hs_run = 0;
			end
			if (vsync) begin
				vs_run = vs_run + 1;
			end else if (vs_run != 0) begin
				check_equal("vsync length", vs_run, fb_pkg::v_sync * fb_pkg::h_total);
				vs_pulses = vs_pulses + 1;
				vs_run = 0;
			end
			check_equal("underrun", underrun, 0);
		end
		// Frame boundary at the start of vblank
		if (watch && vblank && !vblank_prev) begin
			if (armed) begin
				check_equal("pixels per frame", pix_idx, fb_pkg::frame_words);
				check_equal("lines with de", de_lines, fb_pkg::frame_height);
				check_equal("hsync pulses per frame", hs_pulses, fb_pkg::v_total);
				check_equal("vsync pulses per frame", vs_pulses, 1);
				frames_done = frames_done + 1;
			end
			armed = 1'b1;
			pix_idx = 0;
			de_run = 0;
			de_lines = 0;
			hs_run = 0;
			hs_pulses = 0;
			vs_run = 0;
			vs_pulses = 0;
		end
		vblank_prev = vblank;
	end

	initial begin
		#(limit_clks * clk_period);
		report_error("simulation ran past its time limit");
	end

	initial begin
		int order [fb_pkg::frame_words];
		int i;
		int j;
		int tmp;
		int last_addr;
		seed = 41364;
		clk = 1'b0;
		reset = 1'b1;
		display_en = 1'b0;
		clear_flags = 1'b0;
		pixel_we = 1'b0;
		x = '0;
		y = '0;
		rgb = '0;
		watch = 1'b0;
		armed = 1'b0;
		vblank_prev = 1'b1;
		frames_done = 0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_equal("de", de, 0);
		check_equal("hsync", hsync, 0);
		check_equal("vsync", vsync, 0);
		check_equal("overrun", overrun, 0);
		check_equal("underrun", underrun, 0);
		check_equal("tft_rgb", tft_rgb, 0);
		check_equal("hblank", hblank, 1);
		check_equal("vblank", vblank, 1);

		// Every pixel once in shuffled order
		for (i = 0; i < fb_pkg::frame_words; i++)
			order[i] = i;
		for (i = fb_pkg::frame_words - 1; i > 0; i--) begin
			j = rand_below(i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (i = 0; i < fb_pkg::frame_words; i++)
			write_pixel(order[i], random_color());
		repeat (8) @(posedge clk);
		@(negedge clk);
		check_equal("overrun", overrun, 0);

		show_frames(2);

		// Fetch refill holds the memory so the queue fills
		write_burst(last_addr);
		repeat (16) @(posedge clk);
		@(negedge clk);
		check_equal("overrun", overrun, 1);
		@(posedge clk);
		clear_flags <= 1'b1;
		@(posedge clk);
		clear_flags <= 1'b0;
		@(negedge clk);
		check_equal("overrun", overrun, 0);
		write_pixel(last_addr, random_color());
		repeat (8) @(posedge clk);
		show_frames(1);

		// Random subset between frames
		for (i = 0; i < subset_writes; i++)
			write_pixel(rand_below(fb_pkg::frame_words), random_color());
		repeat (8) @(posedge clk);
		show_frames(1);
		@(negedge clk);
		check_equal("overrun", overrun, 0);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
